//--- source/drum_pkg.sv
`default_nettype none

package drum_pkg;

	////////////////////
	// Grid geometry
	////////////////////
	localparam int n_cols = 8;
	localparam int n_rows = 16;
	// Strike point and audio tap
	localparam int center_col = 4;
	localparam int center_row = 8;

	typedef logic [3:0] row_idx_t;
	// Signed 1.17 displacement
	typedef logic signed [17:0] node_t;

	////////////////////
	// Tension and update
	////////////////////
	// 0.25 in 1.17
	localparam node_t rho_base = 18'h08000;
	// Upper bound on effective tension
	localparam node_t rho_max = 18'h0FAE1;
	localparam int center_shift = 4;
	localparam int prev_leak_shift = 10;
	localparam int damp_shift = 9;
	// Node value to audio word
	localparam int sample_shift = 14;

	////////////////////
	// Audio bus
	////////////////////
	typedef logic [31:0] audio_word_t;
	typedef logic [31:0] bus_addr_t;

	localparam bus_addr_t fifo_addr = 32'h0000_3044;
	localparam bus_addr_t left_addr = 32'h0000_3048;
	localparam bus_addr_t right_addr = 32'h0000_304C;
	// Need more than this many free words for a pair
	localparam int fifo_space_min = 2;

	typedef struct packed {
		bus_addr_t addr;
		logic [3:0] byte_enable;
		logic read;
		logic write;
		audio_word_t write_data;
	} bus_req_t;

	// Phase seen by every column, idle doubles as the audio hold
	typedef enum logic [1:0] {
		phase_idle,
		phase_init,
		phase_prime,
		phase_update
	} sweep_phase_t;

	// 1.17 signed multiply, sign bit plus bits 33..17 of the product
	function automatic node_t fixed_mult(input node_t a, input node_t b);
		logic signed [35:0] prod;
		prod = a * b;
		return {prod[35], prod[33:17]};
	endfunction

endpackage

`default_nettype wire

//--- source/drum_node_update.sv
`timescale 1ns/1ps
`default_nettype none

module drum_node_update (
	input wire drum_pkg::node_t curr_u,
	input wire drum_pkg::node_t prev_u,
	input wire drum_pkg::node_t u_left,
	input wire drum_pkg::node_t u_right,
	input wire drum_pkg::node_t u_up,
	input wire drum_pkg::node_t u_down,
	input wire drum_pkg::node_t rho_eff,
	output drum_pkg::node_t next_u
);
	import drum_pkg::*;

	node_t u_sum;
	node_t rho_term;
	node_t inter_u;

	// Discrete Laplacian over the four neighbours
	assign u_sum = (u_left - curr_u) + (u_right - curr_u) + (u_up - curr_u) + (u_down - curr_u);
	assign rho_term = fixed_mult(u_sum, rho_eff);

	// Leapfrog step with a small leak of the previous value
	assign inter_u = rho_term + (curr_u <<< 1) - prev_u + (prev_u >>> prev_leak_shift);

	// Damping
	assign next_u = inter_u - (inter_u >>> damp_shift);

endmodule

`default_nettype wire

//--- source/column_ram.sv
`timescale 1ns/1ps
`default_nettype none

module column_ram (
	input wire CLOCK_50,
	input wire we,
	input wire drum_pkg::row_idx_t wr_addr,
	input wire drum_pkg::row_idx_t rd_addr,
	input wire drum_pkg::node_t d,
	output drum_pkg::node_t q
);
	import drum_pkg::*;

	// One word per row
	node_t mem [n_rows];

	always_ff @(posedge CLOCK_50) begin
		if (we) begin
			mem[wr_addr] <= d;
		end
		// Old contents on a same-address write
		q <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- source/drum_column.sv
`timescale 1ns/1ps
`default_nettype none

module drum_column (
	input wire CLOCK_50,
	input wire arst_n,
	input wire drum_pkg::sweep_phase_t phase,
	input wire drum_pkg::row_idx_t row,
	input wire drum_pkg::node_t init_amp,
	input wire drum_pkg::node_t left_u,
	input wire drum_pkg::node_t right_u,
	input wire drum_pkg::node_t center_sample,
	output drum_pkg::node_t curr_u
);
	import drum_pkg::*;

	// Row pipeline, cur_reg is the row being updated
	node_t up_reg;
	node_t cur_reg;
	node_t down_reg;
	node_t prev_reg;
	// New row 0 value, wraps into the next sweep
	node_t bottom_reg;

	node_t q_curr;
	node_t q_prev;
	node_t init_val;
	node_t d_curr;
	node_t d_prev;
	node_t u_up;
	node_t u_down;
	node_t next_u;

	node_t center_scaled;
	node_t center_sq;
	node_t rho_sum;
	node_t rho_eff;

	row_idx_t rd_curr;
	row_idx_t rd_prev;
	logic we;
	logic first_row;
	logic top_row;

	assign first_row = (row == '0);
	assign top_row = (row == row_idx_t'(n_rows - 1));

	////////////////////
	// Tension
	////////////////////
	assign center_scaled = center_sample >>> center_shift;
	assign center_sq = fixed_mult(center_scaled, center_scaled);
	assign rho_sum = rho_base + center_sq;
	assign rho_eff = (rho_sum > rho_max) ? rho_max : rho_sum;

	////////////////////
	// Memory ports
	////////////////////
	// Read ahead, two rows for current and one for previous
	// Init only needs row 0 ready for the first prime cycle
	assign rd_curr = (phase == phase_init) ? row + row_idx_t'(1) : row + row_idx_t'(3);
	assign rd_prev = row + row_idx_t'(2);
	assign we = (phase == phase_init) || (phase == phase_update);

	// Strike shape, single raised node
	assign init_val = (row == row_idx_t'(center_row)) ? init_amp : '0;

	always_comb begin
		if (phase == phase_init) begin
			d_curr = init_val;
			d_prev = init_val;
		end else begin
			d_curr = next_u;
			// Old value becomes the previous step
			d_prev = cur_reg;
		end
	end

	column_ram curr_ram_inst (
		.CLOCK_50(CLOCK_50),
		.we(we),
		.wr_addr(row),
		.rd_addr(rd_curr),
		.d(d_curr),
		.q(q_curr)
	);

	column_ram prev_ram_inst (
		.CLOCK_50(CLOCK_50),
		.we(we),
		.wr_addr(row),
		.rd_addr(rd_prev),
		.d(d_prev),
		.q(q_prev)
	);

	////////////////////
	// Node update
	////////////////////
	// Fixed edges at bottom and top
	assign u_down = first_row ? '0 : down_reg;
	assign u_up = top_row ? '0 : up_reg;

	drum_node_update node_update_inst (
		.curr_u(cur_reg),
		.prev_u(prev_reg),
		.u_left(left_u),
		.u_right(right_u),
		.u_up(u_up),
		.u_down(u_down),
		.rho_eff(rho_eff),
		.next_u(next_u)
	);

	// Shift one row per cycle, frozen in hold
	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			up_reg <= '0;
			cur_reg <= '0;
			down_reg <= '0;
			prev_reg <= '0;
			bottom_reg <= '0;
		end else if (phase == phase_prime || phase == phase_update) begin
			up_reg <= q_curr;
			prev_reg <= q_prev;
			down_reg <= cur_reg;
			if (phase == phase_update && top_row) begin
				cur_reg <= bottom_reg;
			end else begin
				cur_reg <= up_reg;
			end
			if (phase == phase_update && first_row) begin
				bottom_reg <= next_u;
			end
		end
	end

	// Neighbours see the pre-update value
	assign curr_u = cur_reg;

endmodule

`default_nettype wire

//--- source/drum_grid.sv
`timescale 1ns/1ps
`default_nettype none

module drum_grid (
	input wire CLOCK_50,
	input wire arst_n,
	input wire drum_pkg::sweep_phase_t phase,
	input wire drum_pkg::row_idx_t row,
	input wire sweep_done,
	input wire drum_pkg::node_t strike_amp,
	output drum_pkg::node_t center_sample
);
	import drum_pkg::*;

	node_t col_u [n_cols];
	// Centre node seen during the sweep
	node_t tap_u;

	for (genvar c = 0; c < n_cols; c++) begin : g_col
		node_t left_u;
		node_t right_u;
		node_t init_amp;

		// Zero displacement beyond the side edges
		if (c == 0) begin : g_left_edge
			assign left_u = '0;
		end else begin : g_left_inner
			assign left_u = col_u[c - 1];
		end

		if (c == n_cols - 1) begin : g_right_edge
			assign right_u = '0;
		end else begin : g_right_inner
			assign right_u = col_u[c + 1];
		end

		// Only the struck column gets an amplitude
		assign init_amp = (c == center_col) ? strike_amp : '0;

		drum_column column_inst (
			.CLOCK_50(CLOCK_50),
			.arst_n(arst_n),
			.phase(phase),
			.row(row),
			.init_amp(init_amp),
			.left_u(left_u),
			.right_u(right_u),
			.center_sample(center_sample),
			.curr_u(col_u[c])
		);
	end

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			tap_u <= '0;
		end else if (phase == phase_update && row == row_idx_t'(center_row)) begin
			tap_u <= col_u[center_col];
		end
	end

	// Held constant for a whole sweep, feeds tension and audio
	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			center_sample <= '0;
		end else if (phase == phase_init) begin
			center_sample <= strike_amp;
		end else if (sweep_done) begin
			center_sample <= tap_u;
		end
	end

endmodule

`default_nettype wire

//--- source/sweep_control.sv
`timescale 1ns/1ps
`default_nettype none

module sweep_control (
	input wire CLOCK_50,
	input wire arst_n,
	input wire sample_taken,
	output drum_pkg::sweep_phase_t phase,
	output drum_pkg::row_idx_t row,
	output logic sweep_done,
	output logic sample_ready
);
	import drum_pkg::*;

	logic last_row;

	assign last_row = (row == row_idx_t'(n_rows - 1));

	// Phase register is the FSM state
	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			phase <= phase_init;
			row <= '0;
		end else begin
			case (phase)
				phase_init: begin
					if (last_row) begin
						// Two prime cycles end on the last row index
						phase <= phase_prime;
						row <= row_idx_t'(n_rows - 2);
					end else begin
						row <= row + row_idx_t'(1);
					end
				end
				phase_prime: begin
					if (last_row) begin
						phase <= phase_update;
						row <= '0;
					end else begin
						row <= row + row_idx_t'(1);
					end
				end
				phase_update: begin
					if (last_row) begin
						// Row stays put so read-ahead points at the next sweep
						phase <= phase_idle;
					end else begin
						row <= row + row_idx_t'(1);
					end
				end
				default: begin
					// Hold until the pair is on the bus
					if (sample_taken) begin
						phase <= phase_update;
						row <= '0;
					end
				end
			endcase
		end
	end

	assign sweep_done = (phase == phase_update) && last_row;
	assign sample_ready = (phase == phase_idle);

endmodule

`default_nettype wire

//--- source/audio_bus_master.sv
`timescale 1ns/1ps
`default_nettype none

module audio_bus_master (
	input wire CLOCK_50,
	input wire arst_n,
	input wire sample_ready,
	input wire drum_pkg::node_t center_sample,
	input wire bus_ack,
	input wire drum_pkg::audio_word_t bus_read_data,
	output drum_pkg::bus_req_t bus_req,
	output logic sample_taken
);
	import drum_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_read,
		st_check,
		st_left,
		st_gap,
		st_right
	} master_state_t;

	master_state_t state;
	// Free words reported by the audio FIFO
	logic [7:0] fifo_space;
	audio_word_t sample_word;

	// Sign extend then scale to the codec word
	assign sample_word = {{($bits(audio_word_t) - $bits(node_t)){center_sample[17]}},
		center_sample} << sample_shift;

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			bus_req <= '0;
			fifo_space <= '0;
		end else begin
			case (state)
				st_idle: begin
					// Poll space before each pair
					if (sample_ready) begin
						bus_req.addr <= fifo_addr;
						bus_req.byte_enable <= 4'hF;
						bus_req.read <= 1'b1;
						state <= st_read;
					end
				end
				st_read: begin
					if (bus_ack) begin
						// Space count sits in the top byte
						fifo_space <= bus_read_data[31:24];
						bus_req.read <= 1'b0;
						state <= st_check;
					end
				end
				st_check: begin
					if (fifo_space > fifo_space_min) begin
						bus_req.addr <= left_addr;
						bus_req.write_data <= sample_word;
						bus_req.write <= 1'b1;
						state <= st_left;
					end else begin
						// Too full, ask again
						state <= st_idle;
					end
				end
				st_left: begin
					if (bus_ack) begin
						bus_req.write <= 1'b0;
						state <= st_gap;
					end
				end
				st_gap: begin
					// Same data to the right channel
					bus_req.addr <= right_addr;
					bus_req.write <= 1'b1;
					state <= st_right;
				end
				default: begin
					if (bus_ack) begin
						bus_req.write <= 1'b0;
						state <= st_idle;
					end
				end
			endcase
		end
	end

	// Pair complete, releases the grid
	assign sample_taken = (state == st_right) && bus_ack;

endmodule

`default_nettype wire

//--- source/drum_synth_top.sv
`timescale 1ns/1ps
`default_nettype none

module drum_synth_top (
	input wire CLOCK_50,
	input wire arst_n,
	input wire drum_pkg::node_t strike_amp,
	input wire bus_ack,
	input wire drum_pkg::audio_word_t bus_read_data,
	output drum_pkg::bus_req_t bus_req
);
	import drum_pkg::*;

	sweep_phase_t phase;
	row_idx_t row;
	logic sweep_done;
	logic sample_ready;
	logic sample_taken;
	node_t center_sample;

	////////////////////
	// Sweep sequencing
	////////////////////
	sweep_control sweep_control_inst (
		.CLOCK_50(CLOCK_50),
		.arst_n(arst_n),
		.sample_taken(sample_taken),
		.phase(phase),
		.row(row),
		.sweep_done(sweep_done),
		.sample_ready(sample_ready)
	);

	// Membrane columns and centre tap
	drum_grid drum_grid_inst (
		.CLOCK_50(CLOCK_50),
		.arst_n(arst_n),
		.phase(phase),
		.row(row),
		.sweep_done(sweep_done),
		.strike_amp(strike_amp),
		.center_sample(center_sample)
	);

	////////////////////
	// Audio FIFO writes
	////////////////////
	audio_bus_master audio_bus_master_inst (
		.CLOCK_50(CLOCK_50),
		.arst_n(arst_n),
		.sample_ready(sample_ready),
		.center_sample(center_sample),
		.bus_ack(bus_ack),
		.bus_read_data(bus_read_data),
		.bus_req(bus_req),
		.sample_taken(sample_taken)
	);

endmodule

`default_nettype wire

//--- dv/drum_synth_properties.sv
`timescale 1ns/1ps
`default_nettype none

module drum_synth_properties (
	input wire CLOCK_50,
	input wire arst_n,
	input wire drum_pkg::bus_req_t bus_req,
	input wire bus_ack
);
	import drum_pkg::*;

	logic strobe;

	assign strobe = bus_req.read || bus_req.write;

	// One transfer direction at a time
	read_write_exclusive: assert property (
		@(posedge CLOCK_50) disable iff (!arst_n)
		!(bus_req.read && bus_req.write)
	) else $error("bus read and write strobes high together");

	// Address, data and strobes frozen while waiting for ack
	request_held: assert property (
		@(posedge CLOCK_50) disable iff (!arst_n)
		strobe && !bus_ack |=> $stable(bus_req)
	) else $error("bus request changed before its ack");

	// Strobe released right after the ack
	strobe_dropped: assert property (
		@(posedge CLOCK_50) disable iff (!arst_n)
		strobe && bus_ack |=> !strobe
	) else $error("bus strobe still high after ack");

	// Only the two codec channels are written
	write_target: assert property (
		@(posedge CLOCK_50) disable iff (!arst_n)
		bus_req.write |-> (bus_req.addr == left_addr || bus_req.addr == right_addr)
	) else $error("bus write to an address other than a channel");

endmodule

`default_nettype wire

//--- dv/drum_synth_tb.sv
`timescale 1ns/1ps
`default_nettype none

module drum_synth_tb;
	import drum_pkg::*;

	localparam int reset_cycles = 16;
	localparam int pairs_per_run = 40;
	localparam int n_runs = 2;
	// Generous bound on one sweep plus polling and two slow writes
	localparam int cycles_per_pair = 400;
	localparam int timeout_cycles = pairs_per_run * n_runs * cycles_per_pair;

	logic CLOCK_50;
	logic arst_n;
	node_t strike_amp;
	logic bus_ack;
	audio_word_t bus_read_data;
	bus_req_t bus_req;

	int error_count = 0;
	int cycle_count = 0;
	logic [31:0] lcg_state = 32'h9d41_f858;
	logic [31:0] rnd;

	// Bus slave state
	// Reset level as seen at the clock edge
	logic arst_sampled;
	logic pending = 1'b0;
	int wait_left = 0;
	// 0 expects a FIFO read, 1 the left write, 2 the right write
	int bus_expect = 0;
	bus_req_t held_req;
	logic [7:0] space;
	audio_word_t left_word;
	audio_word_t pair_words [$];

	// Reference membrane
	int grid_u [n_cols][n_rows];
	int grid_prev [n_cols][n_rows];
	int last_sample;

	drum_synth_top drum_synth_top_inst (
		.CLOCK_50(CLOCK_50),
		.arst_n(arst_n),
		.strike_amp(strike_amp),
		.bus_ack(bus_ack),
		.bus_read_data(bus_read_data),
		.bus_req(bus_req)
	);

	bind audio_bus_master drum_synth_properties bus_properties_inst (
		.CLOCK_50(CLOCK_50),
		.arst_n(arst_n),
		.bus_req(bus_req),
		.bus_ack(bus_ack)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #50 CLOCK_50 = ~CLOCK_50;
	end

	////////////////////
	// Checking helpers
	////////////////////
	task automatic report_error(input string what);
		error_count++;
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input audio_word_t got, input audio_word_t exp);
		if (got !== exp) begin
			report_error($sformatf("Error: %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_addr(input string name, input bus_addr_t got, input bus_addr_t exp);
		if (got !== exp) begin
			report_error($sformatf("Error: %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_enable(input string name, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp) begin
			report_error($sformatf("Error: %s got %h expected %h", name, got, exp));
		end
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	////////////////////
	// Reference model
	////////////////////
	// Two's complement wrap to 18 bits
	function automatic int wrap18(input longint v);
		longint m;
		m = v & 64'h3_FFFF;
		if (m >= 64'h2_0000) begin
			m = m - 64'h4_0000;
		end
		return int'(m);
	endfunction

	// 1.17 product keeping the sign bit over bits 33..17
	function automatic int scale_product(input int a, input int b);
		longint prod;
		longint kept;
		prod = longint'(a) * longint'(b);
		kept = (((prod >>> 35) & 64'd1) << 17) | ((prod >>> 17) & 64'h1_FFFF);
		return wrap18(kept);
	endfunction

	// Base tension plus scaled centre squared with clamp
	function automatic int tension_for(input int sample);
		int scaled;
		int sum;
		int rho;
		scaled = sample >>> center_shift;
		sum = wrap18(int'(rho_base) + scale_product(scaled, scaled));
		if (sum > int'(rho_max)) begin
			rho = int'(rho_max);
		end else begin
			rho = sum;
		end
		return rho;
	endfunction

	function automatic void load_grid(input int amp);
		int c;
		int r;
		for (c = 0; c < n_cols; c++) begin
			for (r = 0; r < n_rows; r++) begin
				grid_u[c][r] = 0;
			end
		end
		grid_u[center_col][center_row] = amp;
		grid_prev = grid_u;
	endfunction

	// One time step over the whole grid using old neighbour values
	function automatic void step_grid(input int rho);
		int next_u [n_cols][n_rows];
		int c;
		int r;
		int lft;
		int rgt;
		int up;
		int dn;
		int c0;
		int p0;
		int lap;
		int inter;
		for (c = 0; c < n_cols; c++) begin
			for (r = 0; r < n_rows; r++) begin
				c0 = grid_u[c][r];
				p0 = grid_prev[c][r];
				// Zero displacement outside the membrane
				lft = (c == 0) ? 0 : grid_u[c - 1][r];
				rgt = (c == n_cols - 1) ? 0 : grid_u[c + 1][r];
				dn = (r == 0) ? 0 : grid_u[c][r - 1];
				up = (r == n_rows - 1) ? 0 : grid_u[c][r + 1];
				lap = wrap18(lft + rgt + up + dn - 4 * c0);
				inter = wrap18(scale_product(lap, rho) + 2 * c0 - p0 + (p0 >>> prev_leak_shift));
				next_u[c][r] = wrap18(inter - (inter >>> damp_shift));
			end
		end
		grid_prev = grid_u;
		grid_u = next_u;
	endfunction

	function automatic audio_word_t sample_word_of(input int s);
		return audio_word_t'(s <<< sample_shift);
	endfunction

	////////////////////
	// Bus slave model
	////////////////////
	task automatic start_request();
		held_req = bus_req;
		rnd = lcg_next();
		wait_left = int'(rnd[30:28]);
		pending = 1'b1;
		check_enable("bus_req.byte_enable", bus_req.byte_enable, 4'hF);
		if (bus_req.read) begin
			check_addr("bus_req.addr", bus_req.addr, fifo_addr);
			if (bus_expect != 0) begin
				report_error("Error: FIFO read issued in the middle of a channel pair");
			end
		end else if (bus_expect == 0) begin
			report_error("Error: channel write issued without a FIFO read reporting space");
		end else if (bus_expect == 1) begin
			check_addr("bus_req.addr", bus_req.addr, left_addr);
		end else begin
			check_addr("bus_req.addr", bus_req.addr, right_addr);
		end
	endtask

	task automatic finish_request();
		bus_ack = 1'b1;
		if (held_req.read) begin
			// Space 0..7 so the low cases come up often
			rnd = lcg_next();
			space = {5'b0, rnd[26:24]};
			bus_read_data = {space, rnd[23:0]};
			bus_expect = (space > fifo_space_min) ? 1 : 0;
		end else if (bus_expect == 1) begin
			left_word = held_req.write_data;
			bus_expect = 2;
		end else begin
			check_word("bus_req.write_data", held_req.write_data, left_word);
			pair_words.push_back(held_req.write_data);
			bus_expect = 0;
		end
	endtask

	always @(posedge CLOCK_50) begin
		arst_sampled = arst_n;
		#1;
		if (!arst_sampled) begin
			if (bus_req.read || bus_req.write) begin
				report_error("Error: bus strobe active while reset is asserted");
			end
			bus_ack = 1'b0;
			pending = 1'b0;
			bus_expect = 0;
		end else begin
			if (bus_ack) begin
				// Ack lasts a single cycle
				bus_ack = 1'b0;
				pending = 1'b0;
				if (bus_req.read || bus_req.write) begin
					report_error("Error: bus strobe still high in the cycle after its ack");
				end
			end else if (bus_req.read || bus_req.write) begin
				if (bus_req.read && bus_req.write) begin
					report_error("Error: bus read and write strobes high together");
				end
				if (!pending) begin
					start_request();
				end else if (bus_req !== held_req) begin
					report_error("Error: bus request changed before its ack");
				end
				if (wait_left == 0) begin
					finish_request();
				end else begin
					wait_left--;
				end
			end
		end
	end

	always @(posedge CLOCK_50) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("Error: timeout, the run did not finish within %0d cycles", timeout_cycles);
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	////////////////////
	// Stimulus and compare
	////////////////////
	task automatic run_strike(input node_t amp);
		int n;
		int expected;
		audio_word_t got;
		@(posedge CLOCK_50);
		#1;
		arst_n = 1'b0;
		strike_amp = amp;
		repeat (reset_cycles) @(posedge CLOCK_50);
		#1;
		pair_words.delete();
		arst_n = 1'b1;
		@(posedge CLOCK_50);
		#1;
		if (bus_req.read || bus_req.write) begin
			report_error("Error: bus strobe active right after reset");
		end
		load_grid(int'(amp));
		last_sample = int'(amp);
		for (n = 1; n <= pairs_per_run; n++) begin
			while (pair_words.size() == 0) begin
				@(posedge CLOCK_50);
			end
			got = pair_words.pop_front();
			// Audio tap sees the centre before this sweep rewrites it
			expected = grid_u[center_col][center_row];
			// Tension follows the previous sample
			step_grid(tension_for(last_sample));
			last_sample = expected;
			check_word("bus_req.write_data", got, sample_word_of(expected));
		end
	endtask

	initial begin
		arst_n = 1'b0;
		strike_amp = '0;
		bus_ack = 1'b0;
		bus_read_data = '0;
		run_strike(18'h04000);
		// Silent membrane
		run_strike('0);
		if (error_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
source/drum_pkg.sv
source/drum_node_update.sv
source/column_ram.sv
source/drum_column.sv
source/drum_grid.sv
source/sweep_control.sv
source/audio_bus_master.sv
source/drum_synth_top.sv
dv/drum_synth_properties.sv
dv/drum_synth_tb.sv
